/* compile.f */
src/cc_sample_pkg.sv
src/cc_ctrl_pkg.sv
src/frame_fetch.sv
src/lag_correlator.sv
src/peak_tracker.sv
src/cc_top.sv
tb/cc_top_tb.sv

/* src/cc_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cc control types: FSM states and the
// per-lag result record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cc_ctrl_pkg;

  localparam int LAG_W = 8;           // lag index and buffer address width

  typedef enum logic [1:0] {
    FETCH_IDLE  = 2'd0,               // nothing captured yet
    FETCH_REQ   = 2'd1,               // send_frame pulse cycle
    FETCH_FILL  = 2'd2,               // taking ring-buffer samples
    FETCH_READY = 2'd3                // frame held, readable
  } fetch_state_e;

  typedef enum logic [1:0] {
    CORR_IDLE  = 2'd0,                // waiting for both frames
    CORR_MAC   = 2'd1,                // alternate x / y reads
    CORR_DRAIN = 2'd2,                // flush read + product stages
    CORR_EMIT  = 2'd3                 // present one lag result
  } corr_state_e;

  typedef struct packed {
    logic               valid;        // one-cycle strobe
    logic               last;         // final lag of the run
    logic [LAG_W-1:0]   lag;
    cc_sample_pkg::acc_t value;       // real part only
  } lag_result_t;

endpackage

/* src/cc_sample_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cc sample formats: complex samples and
// correlation accumulator type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cc_sample_pkg;

  localparam int SAMPLE_W = 16;       // width of one real or imag part
  localparam int ACC_W    = 40;       // headroom for 64 summed products

  // ring-buffer word layout, im in the upper half
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] im;   // bits 31:16
    logic signed [SAMPLE_W-1:0] re;   // bits 15:0
  } sample_t;

  // real part of one lag's correlation sum
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* src/cc_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cc top: two-channel cross-correlation
// with peak lag report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cc_top #(
  parameter int FRAME_LEN = 16            // samples per channel frame
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start_cc,
  input  cc_sample_pkg::sample_t            x_ring_in,
  input  cc_sample_pkg::sample_t            y_ring_in,
  output logic                              x_send_frame,
  output logic                              y_send_frame,
  output logic [cc_ctrl_pkg::LAG_W-1:0]     index,
  output logic                              cc_done,
  output cc_ctrl_pkg::lag_result_t          lag_stream
);

  logic [cc_ctrl_pkg::LAG_W-1:0] rd_addr; // shared by both buffers
  cc_sample_pkg::sample_t        x_rd_data;
  cc_sample_pkg::sample_t        y_rd_data;
  logic                          x_ready;
  logic                          y_ready;
  logic                          corr_busy;
  logic                          fetching; // a fetcher is in req or fill
  logic                          accept;

  // start only while fetchers sit idle/ready and correlator is idle
  assign accept = start_cc && !corr_busy && !fetching;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetching <= 1'b0;
    end else if (accept) begin
      fetching <= 1'b1;
    end else if (x_ready && y_ready) begin
      fetching <= 1'b0;                  // both frames captured
    end
  end

  frame_fetch #(
    .FRAME_LEN (FRAME_LEN),
    .PAD_FRONT (1'b1)                    // x: zeros first
  ) x_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (accept),
    .ring_in     (x_ring_in),
    .send_frame  (x_send_frame),
    .frame_ready (x_ready),
    .rd_addr     (rd_addr),
    .rd_data     (x_rd_data)
  );

  frame_fetch #(
    .FRAME_LEN (FRAME_LEN),
    .PAD_FRONT (1'b0)                    // y: zeros last
  ) y_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (accept),
    .ring_in     (y_ring_in),
    .send_frame  (y_send_frame),
    .frame_ready (y_ready),
    .rd_addr     (rd_addr),
    .rd_data     (y_rd_data)
  );

  lag_correlator #(
    .FRAME_LEN (FRAME_LEN)
  ) correlator (
    .clk     (clk),
    .rst_n   (rst_n),
    .x_ready (x_ready),
    .y_ready (y_ready),
    .rd_addr (rd_addr),
    .x_data  (x_rd_data),
    .y_data  (y_rd_data),
    .result  (lag_stream),               // debug stream, no back-pressure
    .busy    (corr_busy)
  );

  peak_tracker peak (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (accept),                    // old peak dropped at new run
    .result (lag_stream),
    .index  (index),
    .done   (cc_done)
  );

endmodule

/* src/frame_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame fetch: captures one ring-buffer
// frame into a zero-padded read buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module frame_fetch #(
  parameter int FRAME_LEN = 16,           // samples per frame
  parameter bit PAD_FRONT = 1'b0          // 1: zeros in lower half
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start,
  input  cc_sample_pkg::sample_t            ring_in,
  output logic                              send_frame,
  output logic                              frame_ready,
  input  logic [cc_ctrl_pkg::LAG_W-1:0]     rd_addr,
  output cc_sample_pkg::sample_t            rd_data
);

  localparam int BUF_LEN = 2 * FRAME_LEN;
  localparam int AW      = $clog2(BUF_LEN);

  // samples land in one half, the other half holds zeros
  localparam logic [AW-1:0] DATA_BASE = PAD_FRONT ? AW'(FRAME_LEN) : '0;
  localparam logic [AW-1:0] PAD_BASE  = PAD_FRONT ? '0 : AW'(FRAME_LEN);
  localparam logic [AW-1:0] LAST_WR   = AW'(FRAME_LEN - 1);

  cc_ctrl_pkg::fetch_state_e state;
  logic [AW-1:0]             wr_cnt;      // offset inside the data half
  logic                      take_start;

  cc_sample_pkg::sample_t mem [BUF_LEN];

  // start only taken when no capture is running
  assign take_start = start &&
                      (state == cc_ctrl_pkg::FETCH_IDLE ||
                       state == cc_ctrl_pkg::FETCH_READY);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= cc_ctrl_pkg::FETCH_IDLE;
      wr_cnt <= '0;
    end else begin
      case (state)
        cc_ctrl_pkg::FETCH_IDLE,
        cc_ctrl_pkg::FETCH_READY: begin
          if (take_start) state <= cc_ctrl_pkg::FETCH_REQ;
        end
        cc_ctrl_pkg::FETCH_REQ: begin
          wr_cnt <= '0;                   // samples start next cycle
          state  <= cc_ctrl_pkg::FETCH_FILL;
        end
        cc_ctrl_pkg::FETCH_FILL: begin
          wr_cnt <= wr_cnt + 1'b1;
          if (wr_cnt == LAST_WR) state <= cc_ctrl_pkg::FETCH_READY;
        end
        default: state <= cc_ctrl_pkg::FETCH_IDLE;
      endcase
    end
  end

  assign send_frame  = (state == cc_ctrl_pkg::FETCH_REQ);   // one cycle after start
  assign frame_ready = (state == cc_ctrl_pkg::FETCH_READY); // level until next start

  // buffer storage and registered read port
  always_ff @(posedge clk) begin
    if (take_start) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        mem[PAD_BASE + AW'(i)] <= '0;     // wipe the pad half
      end
    end
    if (state == cc_ctrl_pkg::FETCH_FILL) begin
      mem[DATA_BASE + wr_cnt] <= ring_in; // sampled unconditionally
    end
    rd_data <= mem[rd_addr[AW-1:0]];      // data one cycle after addr
  end

endmodule

/* src/lag_correlator.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lag correlator: per-lag conjugate MAC
// over the padded x and y buffers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module lag_correlator #(
  parameter int FRAME_LEN = 16            // lag count is twice this
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              x_ready,
  input  logic                              y_ready,
  output logic [cc_ctrl_pkg::LAG_W-1:0]     rd_addr,
  input  cc_sample_pkg::sample_t            x_data,
  input  cc_sample_pkg::sample_t            y_data,
  output cc_ctrl_pkg::lag_result_t          result,
  output logic                              busy
);

  localparam int                        BUF_LEN = 2 * FRAME_LEN;
  localparam logic [cc_ctrl_pkg::LAG_W-1:0] LAST_IDX = cc_ctrl_pkg::LAG_W'(BUF_LEN - 1);
  localparam logic [cc_ctrl_pkg::LAG_W-1:0] BUF_SIZE = cc_ctrl_pkg::LAG_W'(BUF_LEN);
  // x is zero in its lower half, so n only walks the data half
  localparam logic [cc_ctrl_pkg::LAG_W-1:0] FIRST_N  = cc_ctrl_pkg::LAG_W'(FRAME_LEN);

  cc_ctrl_pkg::corr_state_e state;

  logic [cc_ctrl_pkg::LAG_W-1:0] k;       // current lag
  logic [cc_ctrl_pkg::LAG_W-1:0] n;       // x data-half index within lag
  logic [cc_ctrl_pkg::LAG_W-1:0] y_addr;  // (n - k) mod buffer length
  logic                          phase;   // 0: x read, 1: y read
  logic [1:0]                    drain_cnt;
  logic                          both_q;
  logic                          go;
  logic                          y_rd_q;  // y_data valid this cycle
  logic                          prod_vld;

  cc_sample_pkg::sample_t        x_hold;  // x sample waiting for its y
  logic signed [31:0]            prod_re;
  logic signed [31:0]            prod_im;
  cc_sample_pkg::acc_t           acc;

  // start on the rising edge of both frames ready, not on the held level
  assign go   = x_ready && y_ready && !both_q && (state == cc_ctrl_pkg::CORR_IDLE);
  assign busy = (state != cc_ctrl_pkg::CORR_IDLE) || go;

  // circular y index without relying on a power-of-two length
  assign y_addr  = (n >= k) ? (n - k) : (n + BUF_SIZE - k);
  assign rd_addr = phase ? y_addr : n;    // one shared port, alternating

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= cc_ctrl_pkg::CORR_IDLE;
      k         <= '0;
      n         <= '0;
      phase     <= 1'b0;
      drain_cnt <= '0;
      both_q    <= 1'b0;
      y_rd_q    <= 1'b0;
      prod_vld  <= 1'b0;
    end else begin
      both_q   <= x_ready && y_ready;
      y_rd_q   <= (state == cc_ctrl_pkg::CORR_MAC) && phase;
      prod_vld <= y_rd_q;
      case (state)
        cc_ctrl_pkg::CORR_IDLE: begin
          if (go) begin
            k     <= '0;
            n     <= FIRST_N;
            phase <= 1'b0;
            state <= cc_ctrl_pkg::CORR_MAC;
          end
        end
        cc_ctrl_pkg::CORR_MAC: begin
          phase <= ~phase;
          if (phase) begin
            n <= n + 1'b1;
            if (n == LAST_IDX) begin      // last pair issued
              drain_cnt <= '0;
              state     <= cc_ctrl_pkg::CORR_DRAIN;
            end
          end
        end
        cc_ctrl_pkg::CORR_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'd2) state <= cc_ctrl_pkg::CORR_EMIT;
        end
        cc_ctrl_pkg::CORR_EMIT: begin
          n     <= FIRST_N;
          phase <= 1'b0;
          if (k == LAST_IDX) begin
            state <= cc_ctrl_pkg::CORR_IDLE;
          end else begin
            k     <= k + 1'b1;
            state <= cc_ctrl_pkg::CORR_MAC;
          end
        end
        default: state <= cc_ctrl_pkg::CORR_IDLE;
      endcase
    end
  end

  // data path: x latch, product stage, accumulator
  always_ff @(posedge clk) begin
    if (state == cc_ctrl_pkg::CORR_MAC && phase) begin
      x_hold <= x_data;                   // read from previous x address
    end
    prod_re <= x_hold.re * y_data.re;     // x * conj(y), real part only
    prod_im <= x_hold.im * y_data.im;
    if (state == cc_ctrl_pkg::CORR_IDLE || state == cc_ctrl_pkg::CORR_EMIT) begin
      acc <= '0;                          // fresh sum per lag
    end else if (prod_vld) begin
      acc <= acc + cc_sample_pkg::acc_t'(prod_re) + cc_sample_pkg::acc_t'(prod_im);
    end
  end

  // acc is final and stable through the emit cycle
  always_comb begin
    result.valid = (state == cc_ctrl_pkg::CORR_EMIT);
    result.last  = (state == cc_ctrl_pkg::CORR_EMIT) && (k == LAST_IDX);
    result.lag   = k;
    result.value = acc;
  end

endmodule

/* src/peak_tracker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peak tracker: running argmax of lags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module peak_tracker (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              clear,
  input  cc_ctrl_pkg::lag_result_t          result,
  output logic [cc_ctrl_pkg::LAG_W-1:0]     index,
  output logic                              done
);

  cc_sample_pkg::acc_t best_val;
  logic                have_best;         // first valid result seen
  logic                take;

  // strictly greater, so ties stay at the lower lag
  assign take = result.valid && (!have_best || (result.value > best_val));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      best_val  <= '0;
      have_best <= 1'b0;
      index     <= '0;
      done      <= 1'b0;
    end else begin
      done <= result.valid && result.last; // index settles on the same edge
      if (clear) begin
        best_val  <= '0;
        have_best <= 1'b0;
        index     <= '0;
      end else if (take) begin
        best_val  <= result.value;
        have_best <= 1'b1;
        index     <= result.lag;
      end
    end
  end

endmodule

/* tb/cc_testdata.txt */
// per case: x[0..15] then y[0..15], 8 words per line, 4 lines per case
// each word is {im[15:0], re[15:0]} in hex; case 1 holds a tie at lags 19 and 25
0000FFF0 00000000 00000000 00000000 00000000 00000100 01000000 00000000
00000000 00000000 00000000 00000000 00200010 00000000 00000000 00000000
00000100 01000000 00000000 00000000 00000000 00000000 00000000 FFFE0003
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000064 00000000 00000000 00000000 00000000
00000000 00000064 00000000 00000000 00000000 00000000 0000FFCE 00000000
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

/* tb/cc_top_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cc top testbench: file and random cases
// checked against a direct correlation model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cc_top_tb;

  localparam int FL         = 16;             // frame length under test
  localparam int BL         = 2 * FL;         // padded buffer and lag count
  localparam int FILE_CASES = 2;
  localparam int RAND_CASES = 3;
  localparam int NUM_CASES  = FILE_CASES + RAND_CASES;
  localparam int BUSY_CASE  = 2;              // gets a start while running
  // per run: 2*FL lags of 2*FL MAC cycles plus drain and emit, then capture
  localparam int MAX_CYCLES = NUM_CASES * (4 * FL * FL + 8 * FL + 50);

  logic                          clk;
  logic                          rst_n;
  logic                          start_cc;
  cc_sample_pkg::sample_t        x_ring_in;
  cc_sample_pkg::sample_t        y_ring_in;
  logic                          x_send_frame;
  logic                          y_send_frame;
  logic [cc_ctrl_pkg::LAG_W-1:0] index;
  logic                          cc_done;
  cc_ctrl_pkg::lag_result_t      lag_stream;

  logic [31:0] tdata [0:FILE_CASES*BL-1];     // x words then y words per case
  logic [31:0] xs [0:FL-1];                   // current x frame
  logic [31:0] ys [0:FL-1];                   // current y frame
  longint      exp_corr [0:BL-1];             // model value per lag
  int          exp_peak;
  int          errors;
  int          res_cnt;                       // lag results seen this run
  int          x_pulses;
  int          y_pulses;
  int          cycles;
  integer      seed;

  cc_top #(
    .FRAME_LEN (FL)
  ) i_cc_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_cc     (start_cc),
    .x_ring_in    (x_ring_in),
    .y_ring_in    (y_ring_in),
    .x_send_frame (x_send_frame),
    .y_send_frame (y_send_frame),
    .index        (index),
    .cc_done      (cc_done),
    .lag_stream   (lag_stream)
  );

  always #10 clk = ~clk;                      // 20 ns period

  task automatic check_value(input longint actual, input longint expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // fill xs / ys from the data file or from the seeded generator
  task automatic build_case(input int c);
    int                 shift;
    int                 base;
    logic signed [15:0] re;
    logic signed [15:0] im;
    if (c < FILE_CASES) begin
      base = c * BL;
      for (int i = 0; i < FL; i++) begin
        xs[i] = tdata[base + i];
        ys[i] = tdata[base + FL + i];
      end
    end else begin
      shift = 2 + 4 * (c - FILE_CASES);       // circular delay of x vs y
      for (int i = 0; i < FL; i++) begin
        re    = 16'($random(seed) % 1000);
        im    = 16'($random(seed) % 1000);
        ys[i] = {im, re};
      end
      for (int i = 0; i < FL; i++) begin
        re    = ys[(i - shift + FL) % FL][15:0] + 16'($random(seed) % 4);   // small noise
        im    = ys[(i - shift + FL) % FL][31:16] + 16'($random(seed) % 4);
        xs[i] = {im, re};
      end
    end
  endtask

  // padded circular correlation, real part of x[n] * conj(y[n-k])
  task automatic compute_model();
    int     xr [0:BL-1];
    int     xi [0:BL-1];
    int     yr [0:BL-1];
    int     yi [0:BL-1];
    int     j;
    longint sum;
    for (int n = 0; n < BL; n++) begin
      xr[n] = 0;
      xi[n] = 0;
      yr[n] = 0;
      yi[n] = 0;
    end
    for (int i = 0; i < FL; i++) begin
      xr[FL + i] = $signed(xs[i][15:0]);      // x zeros at front
      xi[FL + i] = $signed(xs[i][31:16]);
      yr[i]      = $signed(ys[i][15:0]);      // y zeros at back
      yi[i]      = $signed(ys[i][31:16]);
    end
    exp_peak = 0;
    for (int k = 0; k < BL; k++) begin
      sum = 0;
      for (int n = 0; n < BL; n++) begin
        j   = (n - k + BL) % BL;
        sum = sum + longint'(xr[n]) * yr[j] + longint'(xi[n]) * yi[j];
      end
      exp_corr[k] = sum;
      if (sum > exp_corr[exp_peak]) exp_peak = k;   // strict, ties keep lower lag
    end
  endtask

  // lag stream and frame request monitor
  always @(negedge clk) begin
    if (rst_n) begin
      if (x_send_frame) x_pulses++;
      if (y_send_frame) y_pulses++;
      if (lag_stream.valid) begin
        check_value(lag_stream.lag, res_cnt, "lag order");
        if (res_cnt < BL) begin
          check_value(lag_stream.value, exp_corr[res_cnt],
                      $sformatf("correlation at lag %0d", res_cnt));
        end
        check_value(lag_stream.last, res_cnt == BL - 1, "last flag");
        res_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles, %0d errors so far",
               MAX_CYCLES, errors);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin : main_flow
    bit               done_seen;
    bit               poked;
    clk       = 1'b0;
    rst_n     = 1'b0;
    start_cc  = 1'b0;
    x_ring_in = '0;
    y_ring_in = '0;
    errors    = 0;
    res_cnt   = 0;
    x_pulses  = 0;
    y_pulses  = 0;
    cycles    = 0;
    seed      = 32'h6763;
    $readmemh("tb/cc_testdata.txt", tdata);
    if ($isunknown(tdata[FILE_CASES*BL-1])) begin
      $display("test data file tb/cc_testdata.txt is missing or too short");
      errors++;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) begin                          // quiet before first start
      @(negedge clk);
      check_value(x_send_frame, 0, "x_send_frame idle after reset");
      check_value(y_send_frame, 0, "y_send_frame idle after reset");
      check_value(cc_done, 0, "cc_done idle after reset");
      check_value(lag_stream.valid, 0, "lag_stream idle after reset");
      check_value(index, 0, "index after reset");
    end
    for (int c = 0; c < NUM_CASES; c++) begin
      build_case(c);
      compute_model();
      res_cnt = 0;
      poked   = 1'b0;
      @(posedge clk);
      start_cc <= 1'b1;
      @(posedge clk);
      start_cc <= 1'b0;
      @(negedge clk);
      check_value(x_send_frame, 1, "x_send_frame one cycle after start");
      check_value(y_send_frame, 1, "y_send_frame one cycle after start");
      for (int i = 0; i < FL; i++) begin
        @(posedge clk);
        x_ring_in <= xs[i];                   // ring buffer sample i
        y_ring_in <= ys[i];
        if (i == 0) begin
          @(negedge clk);
          check_value(x_send_frame, 0, "x_send_frame pulse width");
          check_value(y_send_frame, 0, "y_send_frame pulse width");
        end
      end
      @(posedge clk);
      x_ring_in <= '0;
      y_ring_in <= '0;
      done_seen = 1'b0;
      while (!done_seen) begin
        @(negedge clk);
        if (cc_done) begin
          done_seen = 1'b1;
        end else if (c == BUSY_CASE && res_cnt == 5 && !poked) begin
          poked = 1'b1;                       // start while correlating
          @(posedge clk);
          start_cc <= 1'b1;
          @(posedge clk);
          start_cc <= 1'b0;
        end
      end
      check_value(index, exp_peak, $sformatf("peak index in case %0d", c));
      check_value(res_cnt, BL, "lag result count");
      repeat (5) begin
        @(negedge clk);
        check_value(index, exp_peak, "index held after cc_done");
        check_value(cc_done, 0, "cc_done pulse width");
      end
    end
    check_value(x_pulses, NUM_CASES, "x_send_frame pulse count");
    check_value(y_pulses, NUM_CASES, "y_send_frame pulse count");
    $display("run complete: %0d cases, %0d errors", NUM_CASES, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
